/* common/fe_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch predictor widths, depths, reset vector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

`define FE_IP_W         32
`define FE_BLOCK_BYTES  16
`define FE_SET_W        9    // index from ip[12:4]
`define FE_HIST_W       10
`define FE_TAB_W        10
`define FE_RAS_DEPTH    16

`define FE_RESET_IP     32'h0000_1000

// table flip rate on mispredict
`define FE_THIN_A       8'h03
`define FE_THIN_B       8'h0f
`define FE_THIN_C       8'hff

`endif

/* common/fe_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predictor types and structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fe_params.svh"

package fe_pkg;

  typedef logic [`FE_IP_W-1:0] ip_t;
  typedef logic [`FE_HIST_W-1:0] hist_t;
  typedef logic [`FE_IP_W-`FE_SET_W-5:0] tag_t; // ip[31:13]

  typedef enum logic [1:0] {
    br_cond,
    br_uncond,
    br_call,
    br_ret
  } br_kind_e;

  typedef struct packed {
    logic     valid;
    tag_t     tag;
    ip_t      target;
    br_kind_e kind;
  } tb_entry_t;

  // index 0 is slot 0
  typedef struct packed {
    logic [1:0]     hit;
    br_kind_e [1:0] kind;
    ip_t [1:0]      target;
  } slot_hit_t;

  typedef struct packed {
    logic     valid;
    logic     slot;
    ip_t      src_ip;
    ip_t      target;
    br_kind_e kind;
    logic     mispredict;
    ip_t      next_ip;
    hist_t    hist;
  } retire_t;

  typedef struct packed {
    ip_t   ip;
    hist_t hist;
    logic  taken;
    logic  slot;
    logic  redirect;
  } fetch_t;

endpackage

/* filelist.f */
+incdir+common
common/fe_pkg.sv
predict/dir_predictor.sv
target/target_buffer.sv
target/return_stack.sv
verilog/next_ip.sv
verilog/frontend_top.sv
test/frontend_checker.sv
test/frontend_tb.sv

/* predict/dir_predictor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// three xor-ed direction tables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fe_params.svh"

module dir_predictor import fe_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  ip_t        cur_ip,
  input  hist_t      cur_hist,
  input  retire_t    retire,
  output logic [1:0] pred
);

  localparam int N_TAB = 3;
  localparam int TAB_D = 1 << `FE_TAB_W;
  localparam logic [7:0] THIN_MASK [N_TAB] = '{`FE_THIN_A, `FE_THIN_B, `FE_THIN_C};

  logic [7:0] thin_cnt;
  logic [7:0] thin_nxt;
  logic       train;
  logic [1:0] rd [N_TAB];

  // a: ip bits with short history, b: mostly history, c: history only
  function automatic logic [`FE_TAB_W-1:0] tab_index(input int t, input ip_t ip, input hist_t h);
    case (t)
      0:       tab_index = {ip[11:4], h[1:0]};
      1:       tab_index = {ip[5:4], h[7:0]};
      default: tab_index = h;
    endcase
  endfunction

  assign train    = retire.valid && retire.mispredict;
  assign thin_nxt = thin_cnt + 8'd1;

  always_ff @(posedge clk) begin
    if (rst) begin
      thin_cnt <= 8'd0;
    end else if (train) begin
      thin_cnt <= thin_nxt;
    end
  end

  for (genvar t = 0; t < N_TAB; t++) begin : g_tab
    logic [1:0]           tab [TAB_D]; // one bit per slot
    logic [`FE_TAB_W-1:0] rd_idx;
    logic [`FE_TAB_W-1:0] tr_idx;

    assign rd_idx = tab_index(t, cur_ip, cur_hist);
    assign tr_idx = tab_index(t, retire.src_ip, retire.hist);
    assign rd[t]  = tab[rd_idx];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < TAB_D; i++) begin
          tab[i] <= 2'b00;
        end
      end else if (train && ((thin_nxt & THIN_MASK[t]) == THIN_MASK[t])) begin
        tab[tr_idx][retire.slot] <= ~tab[tr_idx][retire.slot];
      end
    end
  end

  assign pred = rd[0] ^ rd[1] ^ rd[2];

endmodule

/* target/return_stack.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular return address stack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fe_params.svh"

module return_stack import fe_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic pop,
  input  ip_t  push_addr,
  output ip_t  top
);

  localparam int PTR_W = $clog2(`FE_RAS_DEPTH);

  ip_t              stack [`FE_RAS_DEPTH];
  logic [PTR_W-1:0] ptr;     // next free entry
  logic [PTR_W-1:0] ptr_m1;

  assign ptr_m1 = ptr - 1'b1; // wraps on underflow
  assign top    = stack[ptr_m1];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (push) begin
      stack[ptr] <= push_addr;
      ptr        <= ptr + 1'b1;
    end else if (pop) begin
      ptr <= ptr_m1;
    end
  end

endmodule

/* target/target_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-way branch target buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fe_params.svh"

module target_buffer import fe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  ip_t       cur_ip,
  input  retire_t   retire,
  output slot_hit_t hits
);

  localparam int SETS = 1 << `FE_SET_W;

  // way n holds the branch in slot n of the block
  tb_entry_t mem [SETS][2];

  logic [`FE_SET_W-1:0] rd_set;
  logic [`FE_SET_W-1:0] wr_set;
  tag_t                 rd_tag;
  tag_t                 wr_tag;

  assign rd_set = cur_ip[`FE_SET_W+3:4];
  assign rd_tag = cur_ip[`FE_IP_W-1:`FE_SET_W+4];
  assign wr_set = retire.src_ip[`FE_SET_W+3:4];
  assign wr_tag = retire.src_ip[`FE_IP_W-1:`FE_SET_W+4];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hits.hit[w]    = mem[rd_set][w].valid && (mem[rd_set][w].tag == rd_tag);
      hits.kind[w]   = mem[rd_set][w].kind;
      hits.target[w] = mem[rd_set][w].target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < 2; w++) begin
          mem[s][w].valid <= 1'b0; // payload left as is
        end
      end
    end else if (retire.valid) begin
      mem[wr_set][retire.slot] <= '{
        valid:  1'b1,
        tag:    wr_tag,
        target: retire.target,
        kind:   retire.kind
      };
    end
  end

endmodule

/* test/frontend_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of the predictor, per-cycle fetch compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fe_params.svh"

module frontend_checker import fe_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  retire_t retire,
  input  fetch_t  fetch,
  input  logic    test_end,
  input  int      test_num,
  output int      err_cnt,
  output int      chk_cnt
);

  tb_entry_t  m_tb [1 << `FE_SET_W][2];
  logic [1:0] m_tab [3][1 << `FE_TAB_W];
  ip_t        m_ras [`FE_RAS_DEPTH];
  logic [3:0] m_ptr;
  logic [7:0] m_thin;
  ip_t        m_ip;
  hist_t      m_hist;
  logic       m_redir;
  int         test_err;

  initial begin
    err_cnt  = 0;
    chk_cnt  = 0;
    test_err = 0;
  end

  function automatic logic [`FE_TAB_W-1:0] dir_index(input int t, input ip_t a, input hist_t h);
    if (t == 0) return {a[11:4], h[1:0]};
    if (t == 1) return {a[5:4], h[7:0]};
    return h;
  endfunction

  // expected fetch of the modelled state, with next address, history and stack move
  function automatic fetch_t ref_fetch(output ip_t nip, output hist_t nh, output logic [1:0] op);
    fetch_t     f;
    tb_entry_t  e;
    logic       tk;
    logic [1:0] p;
    logic [3:0] below;
    p = m_tab[0][dir_index(0, m_ip, m_hist)] ^ m_tab[1][dir_index(1, m_ip, m_hist)]
        ^ m_tab[2][dir_index(2, m_ip, m_hist)];
    below = m_ptr - 4'd1;
    f   = '{ip: m_ip, hist: m_hist, taken: 1'b0, slot: 1'b0, redirect: m_redir};
    nip = m_ip + 32'd16;
    nh  = m_hist;
    op  = 2'b00; // bit 0 push, bit 1 pop
    for (int s = 0; s < 2; s++) begin
      e = m_tb[m_ip[12:4]][s];
      if (!f.taken && e.valid && e.tag == m_ip[31:13]) begin
        tk = (e.kind != br_cond) || p[s];
        nh = {nh[`FE_HIST_W-2:0], tk};
        if (tk) begin
          f.taken = 1'b1;
          f.slot  = s[0];
          nip     = (e.kind == br_ret) ? m_ras[below] : e.target;
          op      = {e.kind == br_ret, e.kind == br_call};
        end
      end
    end
    return f;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      $display("** Error: fetch.%s expected %h, got %h", name, exp, act);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic flip_dir(input int t);
    logic [`FE_TAB_W-1:0] idx;
    idx = dir_index(t, retire.src_ip, retire.hist);
    m_tab[t][idx][retire.slot] = ~m_tab[t][idx][retire.slot];
  endtask

  always @(posedge clk) begin : model_step
    fetch_t     exp;
    ip_t        nip;
    hist_t      nh;
    logic [1:0] op;
    if (rst) begin
      for (int s = 0; s < (1 << `FE_SET_W); s++) begin
        m_tb[s][0].valid = 1'b0;
        m_tb[s][1].valid = 1'b0;
      end
      for (int i = 0; i < (1 << `FE_TAB_W); i++) begin
        m_tab[0][i] = 2'b00;
        m_tab[1][i] = 2'b00;
        m_tab[2][i] = 2'b00;
      end
      m_ptr   = '0;
      m_thin  = '0;
      m_ip    = `FE_RESET_IP;
      m_hist  = '0;
      m_redir = 1'b0;
    end else begin
      exp = ref_fetch(nip, nh, op);
      check_field("ip", exp.ip, fetch.ip);
      check_field("hist", exp.hist, fetch.hist);
      check_field("taken", exp.taken, fetch.taken);
      check_field("slot", exp.slot, fetch.slot);
      check_field("redirect", exp.redirect, fetch.redirect);
      if (!m_redir && op[0]) begin
        m_ras[m_ptr] = m_ip + 32'd16;
        m_ptr        = m_ptr + 4'd1;
      end else if (!m_redir && op[1]) begin
        m_ptr = m_ptr - 4'd1;
      end
      if (retire.valid) begin
        m_tb[retire.src_ip[12:4]][retire.slot] = '{valid: 1'b1, tag: retire.src_ip[31:13],
                                                   target: retire.target, kind: retire.kind};
      end
      if (retire.valid && retire.mispredict) begin
        m_thin = m_thin + 8'd1;
        if ((m_thin & `FE_THIN_A) == `FE_THIN_A) flip_dir(0);
        if ((m_thin & `FE_THIN_B) == `FE_THIN_B) flip_dir(1);
        if ((m_thin & `FE_THIN_C) == `FE_THIN_C) flip_dir(2);
        m_ip    = retire.next_ip;
        m_hist  = retire.hist;
        m_redir = 1'b1;
      end else begin
        m_ip    = nip;
        m_hist  = nh;
        m_redir = 1'b0;
      end
    end
    if (test_end) begin
      $display("test %0d finished with %0d errors", test_num, test_err);
      test_err = 0;
    end
  end

endmodule

/* test/frontend_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top, clock, reset, stimulus, timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fe_params.svh"

module frontend_tb import fe_pkg::*; ();

  localparam int RAND_N  = 300;
  // reset and end strobe per test, then each test's stimulus length
  localparam int PLANNED = 5 * 9 + 20 + 36 + 788 + 38 + RAND_N + 10;
  localparam int LIMIT   = PLANNED + 200;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  retire_t     retire;
  fetch_t      fetch;
  logic        test_end;
  int          test_num;
  int          err_cnt;
  int          chk_cnt;
  int          cycles = 0;
  logic [31:0] lcg_state = 32'hd1fa;

  always #50 clk = ~clk;

  frontend_top frontend_top_inst (.*);

  frontend_checker checker_inst (.*);

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: run did not end within %0d cycles", LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  // blocks in 0x1000..0x13f0, bit 13 gives a second tag
  function automatic ip_t rand_block();
    logic [31:0] r;
    r = next_rand();
    return 32'h0000_1000 | {18'd0, r[9], 3'd0, r[5:0], 4'd0};
  endfunction

  task automatic do_reset();
    rst    = 1'b1;
    retire = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic send_retire(input logic slot, input ip_t src, input ip_t tgt, input br_kind_e kind,
                             input logic mis, input ip_t nip, input hist_t hist);
    retire = '{valid: 1'b1, slot: slot, src_ip: src, target: tgt, kind: kind,
               mispredict: mis, next_ip: nip, hist: hist};
    @(negedge clk);
    retire = '0;
  endtask

  task automatic install(input logic slot, input ip_t src, input ip_t tgt, input br_kind_e kind);
    send_retire(slot, src, tgt, kind, 1'b0, '0, '0);
  endtask

  task automatic finish_test(input int n);
    test_num = n;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] r;
    logic [1:0]  k;
    retire   = '0;
    test_end = 1'b0;
    test_num = 0;
    // sequential blocks from the reset vector
    do_reset();
    idle(20);
    finish_test(1);
    // slot 0 wins at 0x10a0, slot 1 alone at 0x2040
    do_reset();
    install(1'b1, 32'h10a0, 32'h5000, br_uncond);
    install(1'b0, 32'h10a0, 32'h2000, br_uncond);
    install(1'b1, 32'h2040, 32'h3000, br_uncond);
    idle(33);
    finish_test(2);
    // conditional branch, then repeated mispredicts back onto the block
    do_reset();
    install(1'b0, 32'h1050, 32'h4000, br_cond);
    idle(8);
    send_retire(1'b0, 32'h1050, 32'h4000, br_cond, 1'b1, 32'h4000, 10'h001);
    idle(2);
    repeat (256) begin // counter runs past ff
      send_retire(1'b0, 32'h1050, 32'h4000, br_cond, 1'b1, 32'h1050, 10'h000);
      idle(2);
    end
    idle(8);
    finish_test(3);
    // nested call and return
    do_reset();
    install(1'b0, 32'h1080, 32'h6000, br_call);
    install(1'b0, 32'h6020, 32'h7000, br_call);
    install(1'b1, 32'h7010, 32'h0000, br_ret);
    install(1'b0, 32'h6050, 32'h0000, br_ret);
    idle(34);
    finish_test(4);
    // random retires and mispredicts
    do_reset();
    repeat (RAND_N) begin
      r = next_rand();
      k = (r[5:4] == 2'd3) ? 2'd0 : r[5:4]; // no returns, stack may hold no address
      if (r[2:0] < 3'd4) begin
        send_retire(r[3], rand_block(), rand_block(), br_kind_e'(k), r[7:6] == 2'd0,
                    rand_block(), r[17:8]);
      end else begin
        idle(1);
      end
    end
    idle(10);
    finish_test(5);
    idle(1);
    $display("5 tests, %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/frontend_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch predictor top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frontend_top import fe_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  retire_t retire,
  output fetch_t  fetch
);

  ip_t        cur_ip;
  hist_t      cur_hist;
  slot_hit_t  hits;
  logic [1:0] pred;
  ip_t        top;
  ip_t        push_addr;
  logic       push;
  logic       pop;
  logic       taken;
  logic       slot;
  logic       redirect;

  next_ip next_ip_inst (
    .clk       (clk),
    .rst       (rst),
    .retire    (retire),
    .hits      (hits),
    .pred      (pred),
    .top       (top),
    .cur_ip    (cur_ip),
    .cur_hist  (cur_hist),
    .push      (push),
    .pop       (pop),
    .push_addr (push_addr),
    .taken     (taken),
    .slot      (slot),
    .redirect  (redirect)
  );

  target_buffer target_buffer_inst (
    .clk    (clk),
    .rst    (rst),
    .cur_ip (cur_ip),
    .retire (retire),
    .hits   (hits)
  );

  dir_predictor dir_predictor_inst (
    .clk      (clk),
    .rst      (rst),
    .cur_ip   (cur_ip),
    .cur_hist (cur_hist),
    .retire   (retire),
    .pred     (pred)
  );

  return_stack return_stack_inst (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .pop       (pop),
    .push_addr (push_addr),
    .top       (top)
  );

  assign fetch = '{ip: cur_ip, hist: cur_hist, taken: taken, slot: slot, redirect: redirect};

endmodule

/* verilog/next_ip.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch address, history, next-address select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fe_params.svh"

module next_ip import fe_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  retire_t    retire,
  input  slot_hit_t  hits,
  input  logic [1:0] pred,
  input  ip_t        top,
  output ip_t        cur_ip,
  output hist_t      cur_hist,
  output logic       push,
  output logic       pop,
  output ip_t        push_addr,
  output logic       taken,
  output logic       slot,
  output logic       redirect
);

  logic     [1:0] slot_tk;
  br_kind_e       sel_kind;
  ip_t            sel_target;
  ip_t            seq_ip;
  ip_t            ip_nxt;
  hist_t          hist_nxt;
  logic           fix;

  // unconditional kinds always go, cond ones follow the tables
  assign slot_tk[0] = hits.hit[0] && (hits.kind[0] != br_cond || pred[0]);
  assign slot_tk[1] = hits.hit[1] && (hits.kind[1] != br_cond || pred[1]);

  assign taken      = slot_tk[0] | slot_tk[1];
  assign slot       = ~slot_tk[0] & slot_tk[1]; // slot 0 wins
  assign sel_kind   = hits.kind[slot];
  assign sel_target = hits.target[slot];

  assign seq_ip = cur_ip + ip_t'(`FE_BLOCK_BYTES);

  always_comb begin
    if (!taken) begin
      ip_nxt = seq_ip;
    end else if (sel_kind == br_ret) begin
      ip_nxt = top;
    end else begin
      ip_nxt = sel_target;
    end
  end

  // one bit per examined hit, stop after the taken one
  always_comb begin
    hist_nxt = cur_hist;
    if (hits.hit[0]) begin
      hist_nxt = {hist_nxt[`FE_HIST_W-2:0], slot_tk[0]};
    end
    if (hits.hit[1] && !slot_tk[0]) begin
      hist_nxt = {hist_nxt[`FE_HIST_W-2:0], slot_tk[1]};
    end
  end

  assign push      = taken && (sel_kind == br_call) && !redirect;
  assign pop       = taken && (sel_kind == br_ret) && !redirect;
  assign push_addr = seq_ip;

  assign fix = retire.valid && retire.mispredict;

  always_ff @(posedge clk) begin
    if (rst) begin
      cur_ip   <= `FE_RESET_IP;
      cur_hist <= '0;
      redirect <= 1'b0;
    end else if (fix) begin
      cur_ip   <= retire.next_ip;
      cur_hist <= retire.hist;
      redirect <= 1'b1;
    end else begin
      cur_ip   <= ip_nxt;
      cur_hist <= hist_nxt;
      redirect <= 1'b0;
    end
  end

endmodule
